// File: src/glb_cfg_pkg.sv
`default_nettype none

package glb_cfg_pkg;

    // word and strobe geometry
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int BYTE_OFFSET_WIDTH = $clog2(BANK_STRB_WIDTH);

    // 64 words per bank
    localparam int BANK_WORD_ADDR_WIDTH = 6;

    // tile select sits above the word index
    localparam int TILE_SEL_WIDTH = 3;
    localparam int TILE_SEL_LSB = BYTE_OFFSET_WIDTH + BANK_WORD_ADDR_WIDTH;
    localparam int MAX_NUM_TILES = 2 ** TILE_SEL_WIDTH;
    localparam int DEFAULT_NUM_TILES = 4;

    localparam int GLB_ADDR_WIDTH = TILE_SEL_LSB + TILE_SEL_WIDTH;

endpackage

`default_nettype wire

// File: src/glb_packet_pkg.sv
`default_nettype none

package glb_packet_pkg;

    import glb_cfg_pkg::*;

    typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0] glb_data_t;
    typedef logic [BANK_STRB_WIDTH-1:0] glb_strb_t;

    // processor write, one pulse per word
    typedef struct packed {
        logic      wr_en;
        glb_strb_t wr_strb;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // read request
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // west to east request lane
    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
    } req_packet_t;

    // west to east response lane
    typedef struct packed {
        logic      rd_data_valid;
        glb_data_t rd_data;
    } rsp_packet_t;

endpackage

`default_nettype wire

// File: src/glb_bank.sv
`timescale 1ns/1ps
`default_nettype none

module glb_bank
    import glb_cfg_pkg::*;
    import glb_packet_pkg::*;
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            wr_en,
    input  glb_strb_t                       wr_strb,
    input  logic [BANK_WORD_ADDR_WIDTH-1:0] wr_word_addr,
    input  glb_data_t                       wr_data,
    input  logic                            rd_en,
    input  logic [BANK_WORD_ADDR_WIDTH-1:0] rd_word_addr,
    output glb_data_t                       rd_data,
    output logic                            rd_data_valid
);

    localparam int NUM_WORDS = 2 ** BANK_WORD_ADDR_WIDTH;

    glb_data_t mem [NUM_WORDS];

    // byte-strobe write, read returns the old word on a collision
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_word_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
        if (rd_en) begin
            rd_data <= mem[rd_word_addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// File: src/glb_tile.sv
`timescale 1ns/1ps
`default_nettype none

module glb_tile
    import glb_cfg_pkg::*;
    import glb_packet_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  req_packet_t req_in,
    output req_packet_t req_out,
    input  rsp_packet_t rsp_in,
    output rsp_packet_t rsp_out
);

    localparam logic [TILE_SEL_WIDTH-1:0] TILE_SEL = TILE_ID[TILE_SEL_WIDTH-1:0];

    logic      wr_en_q;
    logic      rd_en_q;
    glb_strb_t wr_strb_q;
    glb_addr_t wr_addr_q;
    glb_data_t wr_data_q;
    glb_addr_t rd_addr_q;

    logic      bank_wr_en;
    logic      bank_rd_en;
    glb_data_t bank_rd_data;
    logic      bank_rd_data_valid;
    glb_data_t bank_rsp_data;

    logic      rsp_valid_q;
    glb_data_t rsp_data_q;

    // request stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
        end else begin
            wr_en_q <= req_in.wr.wr_en;
            rd_en_q <= req_in.rdrq.rd_en;
        end
    end

    always_ff @(posedge clk) begin
        wr_strb_q <= req_in.wr.wr_strb;
        wr_addr_q <= req_in.wr.wr_addr;
        wr_data_q <= req_in.wr.wr_data;
        rd_addr_q <= req_in.rdrq.rd_addr;
    end

    // passes east unchanged
    assign req_out = '{
        wr:   '{wr_en: wr_en_q, wr_strb: wr_strb_q, wr_addr: wr_addr_q, wr_data: wr_data_q},
        rdrq: '{rd_en: rd_en_q, rd_addr: rd_addr_q}
    };

    // tile-id routing
    assign bank_wr_en = wr_en_q && (wr_addr_q[TILE_SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);
    assign bank_rd_en = rd_en_q && (rd_addr_q[TILE_SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);

    glb_bank glb_bank (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr_en         (bank_wr_en),
        .wr_strb       (wr_strb_q),
        .wr_word_addr  (wr_addr_q[BYTE_OFFSET_WIDTH +: BANK_WORD_ADDR_WIDTH]),
        .wr_data       (wr_data_q),
        .rd_en         (bank_rd_en),
        .rd_word_addr  (rd_addr_q[BYTE_OFFSET_WIDTH +: BANK_WORD_ADDR_WIDTH]),
        .rd_data       (bank_rd_data),
        .rd_data_valid (bank_rd_data_valid)
    );

    // bank word only joins the lane while valid
    assign bank_rsp_data = bank_rd_data_valid ? bank_rd_data : '0;

    // fixed latency keeps at most one source valid, so OR merges safely
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rsp_in.rd_data_valid | bank_rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data_q <= rsp_in.rd_data | bank_rsp_data;
    end

    assign rsp_out = '{rd_data_valid: rsp_valid_q, rd_data: rsp_data_q};

endmodule

`default_nettype wire

// File: src/glb_proc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module glb_proc_ctrl
    import glb_cfg_pkg::*;
    import glb_packet_pkg::*;
#(
    parameter int NUM_TILES = DEFAULT_NUM_TILES
) (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        proc_wr_en,
    input  glb_strb_t   proc_wr_strb,
    input  glb_addr_t   proc_wr_addr,
    input  glb_data_t   proc_wr_data,
    input  logic        proc_rd_en,
    input  glb_addr_t   proc_rd_addr,
    output glb_data_t   proc_rd_data,
    output logic        proc_rd_data_valid,

    output req_packet_t req_out,
    input  rsp_packet_t rsp_in
);

    // request register plus tile stages plus last response register
    localparam int RD_DELAY = NUM_TILES + 3;
    localparam int LIMIT_WIDTH = $clog2(MAX_NUM_TILES + 1);

    logic [TILE_SEL_WIDTH-1:0] wr_tile_sel;
    logic [TILE_SEL_WIDTH-1:0] rd_tile_sel;
    logic                      wr_in_range;
    logic                      rd_in_range;

    logic      wr_en_q;
    logic      rd_en_q;
    glb_strb_t wr_strb_q;
    glb_addr_t wr_addr_q;
    glb_data_t wr_data_q;
    glb_addr_t rd_addr_q;

    logic [RD_DELAY-1:0] rd_expect_q;

    assign wr_tile_sel = proc_wr_addr[TILE_SEL_LSB +: TILE_SEL_WIDTH];
    assign rd_tile_sel = proc_rd_addr[TILE_SEL_LSB +: TILE_SEL_WIDTH];
    assign wr_in_range = LIMIT_WIDTH'(wr_tile_sel) < LIMIT_WIDTH'(NUM_TILES);
    assign rd_in_range = LIMIT_WIDTH'(rd_tile_sel) < LIMIT_WIDTH'(NUM_TILES);

    // out-of-range accesses never reach a bank
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
        end else begin
            wr_en_q <= proc_wr_en && wr_in_range;
            rd_en_q <= proc_rd_en && rd_in_range;
        end
    end

    always_ff @(posedge clk) begin
        wr_strb_q <= proc_wr_strb;
        wr_addr_q <= proc_wr_addr;
        wr_data_q <= proc_wr_data;
        rd_addr_q <= proc_rd_addr;
    end

    assign req_out = '{
        wr:   '{wr_en: wr_en_q, wr_strb: wr_strb_q, wr_addr: wr_addr_q, wr_data: wr_data_q},
        rdrq: '{rd_en: rd_en_q, rd_addr: rd_addr_q}
    };

    // every accepted read expects a response, in range or not
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_expect_q <= '0;
        end else begin
            rd_expect_q <= {rd_expect_q[RD_DELAY-2:0], proc_rd_en};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            proc_rd_data_valid <= 1'b0;
        end else begin
            proc_rd_data_valid <= rd_expect_q[RD_DELAY-1];
        end
    end

    // no bank answered an out-of-range read, so it returns zero
    always_ff @(posedge clk) begin
        if (rd_expect_q[RD_DELAY-1]) begin
            proc_rd_data <= rsp_in.rd_data_valid ? rsp_in.rd_data : '0;
        end
    end

endmodule

`default_nettype wire

// File: src/glb_top.sv
`timescale 1ns/1ps
`default_nettype none

module glb_top
    import glb_cfg_pkg::*;
    import glb_packet_pkg::*;
#(
    parameter int NUM_TILES = DEFAULT_NUM_TILES
) (
    input  logic      clk,
    input  logic      arst_n,

    // processor
    input  logic      proc_wr_en,
    input  glb_strb_t proc_wr_strb,
    input  glb_addr_t proc_wr_addr,
    input  glb_data_t proc_wr_data,
    input  logic      proc_rd_en,
    input  glb_addr_t proc_rd_addr,
    output glb_data_t proc_rd_data,
    output logic      proc_rd_data_valid
);

    // entry i feeds tile i, entry NUM_TILES is the east end
    req_packet_t req_lane [NUM_TILES+1];
    rsp_packet_t rsp_lane [NUM_TILES+1];

    // nothing enters the response lane from the west
    assign rsp_lane[0] = '0;

    glb_proc_ctrl #(
        .NUM_TILES (NUM_TILES)
    ) glb_proc_ctrl (
        .clk                (clk),
        .arst_n             (arst_n),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .req_out            (req_lane[0]),
        .rsp_in             (rsp_lane[NUM_TILES])
    );

    for (genvar i = 0; i < NUM_TILES; i++) begin : glb_tile_gen
        glb_tile #(
            .TILE_ID (i)
        ) glb_tile (
            .clk     (clk),
            .arst_n  (arst_n),
            .req_in  (req_lane[i]),
            .req_out (req_lane[i+1]),
            .rsp_in  (rsp_lane[i]),
            .rsp_out (rsp_lane[i+1])
        );
    end

endmodule

`default_nettype wire

// File: dv/glb_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module glb_top_tb
    import glb_cfg_pkg::*;
    import glb_packet_pkg::*;
();

    localparam int NUM_TILES = DEFAULT_NUM_TILES;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_ENTRIES = 26;
    localparam int WATCHDOG_NS = (NUM_ENTRIES + NUM_TILES + 20) * CLK_PERIOD;

    typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD, OP_WRRD} op_e;

    typedef struct packed {
        op_e       op;
        glb_addr_t addr;
        glb_strb_t strb;
    } entry_t;

    // address is {tile, word, byte}, tile 0..3 in range
    localparam entry_t STIM [NUM_ENTRIES] = '{
        '{OP_IDLE, 12'h000, 8'h00},
        '{OP_IDLE, 12'h000, 8'h00},
        '{OP_WR,   12'h008, 8'hff},
        '{OP_WR,   12'h210, 8'hff},
        '{OP_WR,   12'h418, 8'hff},
        '{OP_WR,   12'h620, 8'hff},
        '{OP_RD,   12'h008, 8'h00},
        '{OP_RD,   12'h210, 8'h00},
        '{OP_RD,   12'h418, 8'h00},
        '{OP_RD,   12'h620, 8'h00},
        '{OP_WR,   12'h210, 8'h0f},
        '{OP_WR,   12'h418, 8'ha5},
        '{OP_RD,   12'h210, 8'h00},
        '{OP_RD,   12'h418, 8'h00},
        '{OP_RD,   12'h620, 8'h00},
        '{OP_RD,   12'h008, 8'h00},
        '{OP_RD,   12'h418, 8'h00},
        '{OP_RD,   12'h210, 8'h00},
        '{OP_WRRD, 12'h008, 8'hff},
        '{OP_RD,   12'h008, 8'h00},
        '{OP_RD,   12'h800, 8'h00},
        '{OP_RD,   12'he08, 8'h00},
        '{OP_WR,   12'h810, 8'hff},
        '{OP_RD,   12'h210, 8'h00},
        '{OP_RD,   12'ha08, 8'h00},
        '{OP_IDLE, 12'h000, 8'h00}
    };

    string stim_name [NUM_ENTRIES] = '{
        "idle_reset_0", "idle_reset_1", "full_wr_t0", "full_wr_t1", "full_wr_t2",
        "full_wr_t3", "full_rd_t0", "full_rd_t1", "full_rd_t2", "full_rd_t3",
        "part_wr_t1", "part_wr_t2", "part_rd_t1", "part_rd_t2", "b2b_rd_t3",
        "b2b_rd_t0", "b2b_rd_t2", "b2b_rd_t1", "same_cycle_t0", "after_same_t0",
        "oor_rd_t4", "oor_rd_t7", "oor_wr_t4", "after_oor_t1", "oor_rd_t5", "idle_end"
    };

    logic      clk;
    logic      arst_n;
    logic      proc_wr_en;
    glb_strb_t proc_wr_strb;
    glb_addr_t proc_wr_addr;
    glb_data_t proc_wr_data;
    logic      proc_rd_en;
    glb_addr_t proc_rd_addr;
    glb_data_t proc_rd_data;
    logic      proc_rd_data_valid;

    int          cyc = 0;
    logic [31:0] lfsr_state = 32'd96907;
    logic [7:0]  ref_mem [2**GLB_ADDR_WIDTH];

    // one entry per read still in flight
    glb_data_t exp_data_q [$];
    string     exp_name_q [$];
    int        exp_due_q [$];

    glb_top #(
        .NUM_TILES (NUM_TILES)
    ) i_glb_top (
        .clk                (clk),
        .arst_n             (arst_n),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_word(output glb_data_t w);
        for (int b = 0; b < BANK_DATA_WIDTH; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    function automatic bit in_range(input glb_addr_t addr);
        return int'(addr[TILE_SEL_LSB +: TILE_SEL_WIDTH]) < NUM_TILES;
    endfunction

    function automatic glb_data_t ref_read(input glb_addr_t addr);
        glb_data_t word;
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            word[b*8 +: 8] =
                ref_mem[{addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH], BYTE_OFFSET_WIDTH'(b)}];
        end
        return word;
    endfunction

    task automatic ref_write(input glb_addr_t addr, input glb_strb_t strb, input glb_data_t data);
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                ref_mem[{addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH], BYTE_OFFSET_WIDTH'(b)}] =
                    data[b*8 +: 8];
            end
        end
    endtask

    task automatic apply_entry(input int idx);
        entry_t    e;
        glb_data_t wdata;
        bit        do_wr;
        bit        do_rd;
        e = STIM[idx];
        do_wr = (e.op == OP_WR) || (e.op == OP_WRRD);
        do_rd = (e.op == OP_RD) || (e.op == OP_WRRD);
        wdata = '0;
        if (do_wr) begin
            next_word(wdata);
        end
        proc_wr_en <= do_wr;
        proc_wr_strb <= e.strb;
        proc_wr_addr <= e.addr;
        proc_wr_data <= wdata;
        proc_rd_en <= do_rd;
        proc_rd_addr <= e.addr;
        // the read sees memory from before this cycle's write
        if (do_rd) begin
            exp_data_q.push_back(in_range(e.addr) ? ref_read(e.addr) : '0);
            exp_name_q.push_back(stim_name[idx]);
        end
        if (do_wr && in_range(e.addr)) begin
            ref_write(e.addr, e.strb, wdata);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        // issued at the last rising edge, valid NUM_TILES+4 edges after it
        if (proc_rd_en === 1'b1) begin
            exp_due_q.push_back(cyc + NUM_TILES + 4);
        end
        if (proc_rd_data_valid !== 1'b0) begin
            if (exp_due_q.size() == 0) begin
                stop_with_failure("proc_rd_data_valid went high with no read pending");
            end else begin
                check_value({exp_name_q[0], " latency"}, 64'(exp_due_q[0]), 64'(cyc));
                check_value(exp_name_q[0], exp_data_q[0], proc_rd_data);
                void'(exp_due_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
            stop_with_failure($sformatf("read %s got no response by cycle %0d",
                                        exp_name_q[0], cyc));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("timeout: the run took longer than the tests allow");
    end

    initial begin
        int waited;
        arst_n <= 1'b0;
        proc_wr_en <= 1'b0;
        proc_wr_strb <= '0;
        proc_wr_addr <= '0;
        proc_wr_data <= '0;
        proc_rd_en <= 1'b0;
        proc_rd_addr <= '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            apply_entry(i);
        end
        waited = 0;
        while (exp_due_q.size() != 0 && waited < NUM_TILES + 8) begin
            @(posedge clk);
            waited++;
        end
        // stray valids still get caught here
        repeat (2) @(posedge clk);
        if (exp_due_q.size() != 0) begin
            stop_with_failure($sformatf("%0d read responses never came back", exp_due_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
src/glb_cfg_pkg.sv
src/glb_packet_pkg.sv
src/glb_bank.sv
src/glb_tile.sv
src/glb_proc_ctrl.sv
src/glb_top.sv
dv/glb_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= glb_top_tb
RTL_TOP   ?= glb_top
FILELIST  ?= src.f
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
